/* design/panel_params.svh */
`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// panel geometry, 64 columns by 32 rows
`define ROW_BITS 5
`define COL_BITS 6

// pwm planes, plane 1 is the msb of the mask
`define BRIGHT_LEVELS 6

// row, column and one byte select per pixel half
`define RAM_ADDR_BITS (`ROW_BITS + `COL_BITS + 1)

`endif

/* design/panel_pkg.sv */
`include "panel_params.svh"

package panel_pkg;

    // one bit per brightness plane
    typedef logic [`BRIGHT_LEVELS-1:0] brightness_t;

    // frame memory address, msb first
    typedef struct packed {
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] col;
        logic                 byte_sel;
    } ram_addr_t;

    typedef struct packed {
        ram_addr_t  addr;
        logic [7:0] data;
    } ram_write_t;

endpackage

/* design/cmd_pkg.sv */
`include "panel_params.svh"

package cmd_pkg;

    import panel_pkg::*;

    typedef enum logic [2:0] {
        set_channel,
        clear_channel,
        toggle_plane,
        all_off,
        all_on,
        load_mask
    } settings_op_e;

    // channel is 0 for red, 1 for green, 2 for blue
    typedef struct packed {
        settings_op_e op;
        logic [1:0]   channel;
        logic [2:0]   plane;
        brightness_t  mask;
    } settings_cmd_t;

    typedef enum logic {
        blank,
        pixel
    } write_op_e;

    // row, col and data only matter for pixel writes
    typedef struct packed {
        write_op_e            op;
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] col;
        logic [15:0]          data;
    } write_cmd_t;

endpackage

/* design/cmd_decoder.sv */
`include "panel_params.svh"

module cmd_decoder
    import panel_pkg::*, cmd_pkg::*;
(
    input  logic          clk_in,
    input  logic          reset,
    input  logic [7:0]    rx_byte,
    input  logic          rx_valid,
    output logic          rx_ready,
    output settings_cmd_t settings_cmd,
    output logic          settings_valid,
    output write_cmd_t    write_cmd,
    output logic          write_valid,
    input  logic          write_ready,
    output logic          collecting
);

    typedef enum logic [1:0] {
        st_idle,
        st_mask_arg,
        st_pixel_arg
    } dec_state_e;

    dec_state_e   state;
    logic [1:0]   arg_cnt;
    logic         take;
    logic         byte_is_setting;
    settings_op_e byte_op;
    logic [1:0]   byte_chan;

    // stall only while a write command waits for the writer
    assign rx_ready = !write_valid || write_ready;
    assign take = rx_valid && rx_ready;
    assign collecting = (state != st_idle) || write_valid;

    // single byte opcodes
    always_comb begin
        byte_is_setting = 1'b1;
        byte_op = set_channel;
        case (rx_byte)
            "R", "G", "B": byte_op = set_channel;
            "r", "g", "b": byte_op = clear_channel;
            "1", "2", "3", "4", "5", "6": byte_op = toggle_plane;
            "0": byte_op = all_off;
            "9": byte_op = all_on;
            default: byte_is_setting = 1'b0;
        endcase
    end

    // fold case, R maps to channel 0
    always_comb begin
        case (rx_byte | 8'h20)
            "g": byte_chan = 2'd1;
            "b": byte_chan = 2'd2;
            default: byte_chan = 2'd0;
        endcase
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            arg_cnt <= 2'd0;
            settings_valid <= 1'b0;
            write_valid <= 1'b0;
        end else begin
            settings_valid <= 1'b0;
            if (write_valid && write_ready) begin
                write_valid <= 1'b0;
            end
            if (take) begin
                case (state)
                    st_idle: begin
                        if (byte_is_setting) begin
                            settings_valid <= 1'b1;
                        end else if (rx_byte == "T") begin
                            state <= st_mask_arg;
                        end else if (rx_byte == "P") begin
                            state <= st_pixel_arg;
                            arg_cnt <= 2'd0;
                        end else if (rx_byte == "Z") begin
                            write_valid <= 1'b1;
                        end
                    end
                    st_mask_arg: begin
                        settings_valid <= 1'b1;
                        state <= st_idle;
                    end
                    default: begin
                        arg_cnt <= arg_cnt + 2'd1;
                        // row, col, high byte, low byte
                        if (arg_cnt == 2'd3) begin
                            write_valid <= 1'b1;
                            state <= st_idle;
                        end
                    end
                endcase
            end
        end
    end

    // command payload, filled in place as bytes arrive
    always_ff @(posedge clk_in) begin
        if (take) begin
            case (state)
                st_idle: begin
                    settings_cmd <= '{op: byte_op, channel: byte_chan,
                                      plane: rx_byte[2:0], mask: '0};
                    if (rx_byte == "Z") begin
                        write_cmd.op <= blank;
                    end
                end
                st_mask_arg: begin
                    settings_cmd.op <= load_mask;
                    settings_cmd.mask <= brightness_t'(rx_byte[`BRIGHT_LEVELS-1:0]);
                end
                default: begin
                    case (arg_cnt)
                        2'd0: write_cmd.row <= rx_byte[`ROW_BITS-1:0];
                        2'd1: write_cmd.col <= rx_byte[`COL_BITS-1:0];
                        2'd2: write_cmd.data[15:8] <= rx_byte;
                        default: begin
                            write_cmd.data[7:0] <= rx_byte;
                            write_cmd.op <= pixel;
                        end
                    endcase
                end
            endcase
        end
    end

    // a write can only be pending when no byte was taken for settings
    settings_write_exclusive: assert property (
        @(posedge clk_in) disable iff (reset) !(settings_valid && write_valid)
    );

endmodule

/* design/display_settings.sv */
`include "panel_params.svh"

module display_settings
    import panel_pkg::*, cmd_pkg::*;
(
    input  logic          clk_in,
    input  logic          reset,
    input  settings_cmd_t settings_cmd,
    input  logic          settings_valid,
    output logic [2:0]    rgb_enable,
    output brightness_t   brightness
);

    brightness_t plane_bit;

    // plane 1 is the top bit of the mask
    assign plane_bit = brightness_t'(1) << (`BRIGHT_LEVELS - settings_cmd.plane);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rgb_enable <= 3'b111;
            brightness <= '1;
        end else if (settings_valid) begin
            case (settings_cmd.op)
                set_channel: begin
                    rgb_enable[settings_cmd.channel] <= 1'b1;
                end
                clear_channel: begin
                    rgb_enable[settings_cmd.channel] <= 1'b0;
                end
                toggle_plane: begin
                    brightness <= brightness ^ plane_bit;
                end
                all_off: begin
                    brightness <= '0;
                end
                all_on: begin
                    brightness <= '1;
                end
                load_mask: begin
                    brightness <= settings_cmd.mask;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* design/frame_writer.sv */
`include "panel_params.svh"

module frame_writer
    import panel_pkg::*, cmd_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset,
    input  write_cmd_t write_cmd,
    input  logic       write_valid,
    output logic       write_ready,
    output ram_write_t ram_wr,
    output logic       ram_wr_valid,
    input  logic       ram_wr_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_blank,
        st_pixel
    } wr_state_e;

    wr_state_e                 state;
    logic [`RAM_ADDR_BITS-1:0] sweep_cnt;
    logic                      px_low;
    logic [`ROW_BITS-1:0]      px_row;
    logic [`COL_BITS-1:0]      px_col;
    logic [15:0]               px_data;
    logic                      wr_done;
    logic                      sweep_last;

    // panel wiring: column reversed, byte k lands at select ~k
    function automatic ram_addr_t map_addr(
        input logic [`ROW_BITS-1:0] row,
        input logic [`COL_BITS-1:0] col,
        input logic                 k
    );
        ram_addr_t a;
        a.row = row;
        a.col = ~col;
        a.byte_sel = ~k;
        return a;
    endfunction

    assign write_ready = (state == st_idle);
    assign wr_done = ram_wr_valid && ram_wr_ready;
    assign sweep_last = (sweep_cnt == {`RAM_ADDR_BITS{1'b1}});

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            sweep_cnt <= '0;
            px_low <= 1'b0;
            ram_wr_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (write_valid) begin
                        ram_wr_valid <= 1'b1;
                        sweep_cnt <= '0;
                        px_low <= 1'b0;
                        state <= (write_cmd.op == blank) ? st_blank : st_pixel;
                    end
                end
                st_blank: begin
                    if (wr_done) begin
                        if (sweep_last) begin
                            ram_wr_valid <= 1'b0;
                            state <= st_idle;
                        end else begin
                            sweep_cnt <= sweep_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // high byte, then low byte
                    if (wr_done) begin
                        if (px_low) begin
                            ram_wr_valid <= 1'b0;
                            state <= st_idle;
                        end else begin
                            px_low <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (write_valid && write_ready) begin
            px_row <= write_cmd.row;
            px_col <= write_cmd.col;
            px_data <= write_cmd.data;
        end
    end

    // sweep position decoded so that the memory address counts up
    always_comb begin
        if (state == st_blank) begin
            ram_wr.addr = map_addr(sweep_cnt[`RAM_ADDR_BITS-1 -: `ROW_BITS],
                                   ~sweep_cnt[`COL_BITS:1], ~sweep_cnt[0]);
            ram_wr.data = 8'h00;
        end else begin
            ram_wr.addr = map_addr(px_row, px_col, px_low);
            ram_wr.data = px_low ? px_data[7:0] : px_data[15:8];
        end
    end

    ram_wr_stable: assert property (
        @(posedge clk_in) disable iff (reset)
        ram_wr_valid && !ram_wr_ready |=> ram_wr_valid && $stable(ram_wr)
    );

endmodule

/* design/led_ctrl_top.sv */
module led_ctrl_top
    import panel_pkg::*, cmd_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic [7:0]  rx_byte,
    input  logic        rx_valid,
    output logic        rx_ready,
    output logic [2:0]  rgb_enable,
    output brightness_t brightness,
    output ram_write_t  ram_wr,
    output logic        ram_wr_valid,
    input  logic        ram_wr_ready,
    output logic        busy
);

    settings_cmd_t settings_cmd;
    logic          settings_valid;
    write_cmd_t    write_cmd;
    logic          write_valid;
    logic          write_ready;
    logic          collecting;

    assign busy = collecting || !write_ready;

    cmd_decoder i_cmd_decoder (
        .clk_in         (clk_in),
        .reset          (reset),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .settings_cmd   (settings_cmd),
        .settings_valid (settings_valid),
        .write_cmd      (write_cmd),
        .write_valid    (write_valid),
        .write_ready    (write_ready),
        .collecting     (collecting)
    );

    display_settings i_display_settings (
        .clk_in         (clk_in),
        .reset          (reset),
        .settings_cmd   (settings_cmd),
        .settings_valid (settings_valid),
        .rgb_enable     (rgb_enable),
        .brightness     (brightness)
    );

    frame_writer i_frame_writer (
        .clk_in       (clk_in),
        .reset        (reset),
        .write_cmd    (write_cmd),
        .write_valid  (write_valid),
        .write_ready  (write_ready),
        .ram_wr       (ram_wr),
        .ram_wr_valid (ram_wr_valid),
        .ram_wr_ready (ram_wr_ready)
    );

endmodule

/* bench/led_ctrl_tb.sv */
`include "panel_params.svh"

module led_ctrl_tb
    import panel_pkg::*;
();

    localparam int PERIOD = 4;
    localparam int NUM_CMDS = 300;
    localparam int MAX_BLANKS = 2;
    localparam int MAX_GAP = 3;
    localparam int MAX_STALL = 1;
    localparam int CMD_BYTES = 5;
    localparam int SWEEP_LEN = 1 << `RAM_ADDR_BITS;
    localparam int LIMIT = ((NUM_CMDS * CMD_BYTES * (MAX_GAP + 2)) + MAX_BLANKS * SWEEP_LEN)
                           * (MAX_STALL + 1) * PERIOD + 100 * PERIOD;

    logic        clk_in = 1'b0;
    logic        reset;
    logic [7:0]  rx_byte;
    logic        rx_valid;
    logic        rx_ready;
    logic [2:0]  rgb_enable;
    brightness_t brightness;
    ram_write_t  ram_wr;
    logic        ram_wr_valid;
    logic        ram_wr_ready;
    logic        busy;

    logic [15:0] lfsr_state = 16'd68;
    string       test_name = "reset";

    // reference model of the controller
    logic [2:0]  m_rgb = 3'b111;
    brightness_t m_br = '1;
    int          m_state = 0;
    int          m_args = 0;
    logic [7:0]  m_row;
    logic [7:0]  m_col;
    logic [7:0]  m_hi;
    ram_write_t  exp_q[$];
    // settings show two monitor steps after the byte is seen
    logic [2:0]  snap1_rgb = 3'b111;
    logic [2:0]  snap2_rgb = 3'b111;
    brightness_t snap1_br = '1;
    brightness_t snap2_br = '1;

    led_ctrl_top i_led_ctrl_top (
        .clk_in       (clk_in),
        .reset        (reset),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rgb_enable   (rgb_enable),
        .brightness   (brightness),
        .ram_wr       (ram_wr),
        .ram_wr_valid (ram_wr_valid),
        .ram_wr_ready (ram_wr_ready),
        .busy         (busy)
    );

    always #(PERIOD / 2) clk_in = ~clk_in;

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[6:0], fb};
        end
        return r;
    endfunction

    function automatic logic is_command(input logic [7:0] b);
        case (b)
            "R", "G", "B", "r", "g", "b", "T", "P", "Z": return 1'b1;
            "0", "1", "2", "3", "4", "5", "6", "9": return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_settings(input string name, input logic [2:0] exp_rgb,
                                  input brightness_t exp_br, input logic [2:0] act_rgb,
                                  input brightness_t act_br);
        if (exp_rgb !== act_rgb || exp_br !== act_br) begin
            $display("ERR %s expected rgb=%b brightness=%b actual rgb=%b brightness=%b",
                     name, exp_rgb, exp_br, act_rgb, act_br);
            fail_run();
        end
    endtask

    task automatic check_write(input string name, input ram_write_t exp_w,
                               input ram_write_t act_w);
        if (exp_w !== act_w) begin
            $display("ERR %s expected write=%h actual write=%h", name, exp_w, act_w);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp_f, input logic act_f);
        if (exp_f !== act_f) begin
            $display("ERR %s expected busy=%b actual busy=%b", name, exp_f, act_f);
            fail_run();
        end
    endtask

    task automatic model_byte(input logic [7:0] b);
        ram_write_t w;
        case (m_state)
            0: begin
                case (b)
                    "R": m_rgb[0] = 1'b1;
                    "G": m_rgb[1] = 1'b1;
                    "B": m_rgb[2] = 1'b1;
                    "r": m_rgb[0] = 1'b0;
                    "g": m_rgb[1] = 1'b0;
                    "b": m_rgb[2] = 1'b0;
                    "0": m_br = '0;
                    "9": m_br = '1;
                    "1", "2", "3", "4", "5", "6":
                        m_br = m_br ^ (brightness_t'(1) << (`BRIGHT_LEVELS - (b - 8'h30)));
                    "T": m_state = 1;
                    "P": begin
                        m_state = 2;
                        m_args = 0;
                    end
                    "Z": begin
                        for (int i = 0; i < SWEEP_LEN; i++) begin
                            w.addr = ram_addr_t'(i[`RAM_ADDR_BITS-1:0]);
                            w.data = 8'h00;
                            exp_q.push_back(w);
                        end
                    end
                    default: begin
                    end
                endcase
            end
            1: begin
                m_br = b[`BRIGHT_LEVELS-1:0];
                m_state = 0;
            end
            default: begin
                case (m_args)
                    0: m_row = b;
                    1: m_col = b;
                    2: m_hi = b;
                    default: begin
                        // high byte goes to select 1 with the column mirrored
                        w.addr.row = m_row[`ROW_BITS-1:0];
                        w.addr.col = ~m_col[`COL_BITS-1:0];
                        w.addr.byte_sel = 1'b1;
                        w.data = m_hi;
                        exp_q.push_back(w);
                        w.addr.byte_sel = 1'b0;
                        w.data = b;
                        exp_q.push_back(w);
                        m_state = 0;
                    end
                endcase
                m_args = m_args + 1;
            end
        endcase
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_in) begin
        if (!reset) begin
            check_settings(test_name, snap2_rgb, snap2_br, rgb_enable, brightness);
            // busy while a command is partly received or writes are outstanding
            check_flag(test_name, (m_state != 0) || (exp_q.size() != 0), busy);
            if (ram_wr_valid && ram_wr_ready) begin
                if (exp_q.size() == 0) begin
                    $display("memory write seen while no write was expected");
                    fail_run();
                end else begin
                    check_write(test_name, exp_q.pop_front(), ram_wr);
                end
            end
            if (rx_valid && rx_ready) begin
                model_byte(rx_byte);
            end
            snap2_rgb = snap1_rgb;
            snap2_br = snap1_br;
            snap1_rgb = m_rgb;
            snap1_br = m_br;
        end
    end

    // memory back-pressure of at most one stalled cycle in a row
    always @(posedge clk_in) begin
        #1;
        if (reset || !ram_wr_ready) begin
            ram_wr_ready = 1'b1;
        end else begin
            ram_wr_ready = (rand_bits(2) != 8'd0);
        end
    end

    task automatic send_byte(input logic [7:0] b);
        logic accepted;
        int   gap;
        rx_byte = b;
        rx_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_in);
            accepted = rx_ready;
            @(posedge clk_in);
            #1;
        end
        rx_valid = 1'b0;
        gap = int'(rand_bits(2));
        repeat (gap) begin
            @(posedge clk_in);
            #1;
        end
    endtask

    initial begin
        #(LIMIT);
        $display("timeout after %0d time units, the DUT stopped making progress", LIMIT);
        fail_run();
    end

    initial begin
        int         sel;
        int         blanks;
        logic [7:0] b;
        reset = 1'b1;
        rx_byte = 8'h00;
        rx_valid = 1'b0;
        ram_wr_ready = 1'b0;
        blanks = 0;
        repeat (2) @(posedge clk_in);
        #1;
        reset = 1'b0;
        for (int i = 0; i < NUM_CMDS; i++) begin
            sel = int'(rand_bits(4));
            if (sel <= 5) begin
                test_name = "channel";
                case (rand_bits(2) % 3)
                    0: b = "R";
                    1: b = "G";
                    default: b = "B";
                endcase
                // lower case clears
                if (sel > 2) begin
                    b = b | 8'h20;
                end
                send_byte(b);
            end else if (sel <= 8) begin
                test_name = "plane";
                send_byte(8'h30 + (rand_bits(4) % 10));
            end else if (sel == 9) begin
                test_name = "mask";
                send_byte("T");
                send_byte(rand_bits(8));
            end else if (sel == 12 && blanks < MAX_BLANKS) begin
                test_name = "blank";
                blanks++;
                send_byte("Z");
            end else if (sel <= 12) begin
                test_name = "pixel";
                send_byte("P");
                repeat (4) send_byte(rand_bits(8));
            end else begin
                test_name = "junk";
                b = rand_bits(8);
                while (is_command(b)) begin
                    b = rand_bits(8);
                end
                send_byte(b);
            end
        end
        test_name = "drain";
        while (exp_q.size() != 0 || busy) begin
            @(posedge clk_in);
        end
        repeat (4) @(posedge clk_in);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/panel_pkg.sv
design/cmd_pkg.sv
design/cmd_decoder.sv
design/display_settings.sv
design/frame_writer.sv
design/led_ctrl_top.sv
bench/led_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module led_ctrl_tb -f src.f -o led_ctrl_sim

./obj_dir/led_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
    exit 0
else
    exit 1
fi
